/* rtl/bp_pkg.sv */
`default_nettype none

package bp_pkg;

   //////////////////////////////
   // Sizes
   //////////////////////////////
   localparam int ENTRIES    = 32;
   localparam int INDEX_BITS = 5;            // log2 of ENTRIES
   localparam int HIST_BITS  = INDEX_BITS;   // History folds straight onto the index
   localparam int ADDR_BITS  = 32;
   localparam int LANES      = 2;

   //////////////////////////////
   // 2-bit counter encodings
   //////////////////////////////
   localparam logic [1:0] CNT_STRONG_NT = 2'b00;
   localparam logic [1:0] CNT_STRONG_T  = 2'b11;
   // Weakly taken for the components, weakly gshare for the chooser
   localparam logic [1:0] CNT_RESET     = 2'b10;

   // One fetch lane, lane 0 never looks at ignore
   typedef struct packed {
      logic [ADDR_BITS-1:0] pc;
      logic                 is_branch;
      logic                 ignore;
   } fetch_lane_t;

   // One lane's answer back to fetch
   typedef struct packed {
      logic                 taken;
      logic [HIST_BITS-1:0] history;   // Snapshot to carry down the pipe
   } pred_lane_t;

   // Resolved branch from execute
   typedef struct packed {
      logic                 valid;
      logic [ADDR_BITS-1:0] pc;
      logic                 taken;       // Actual outcome
      logic                 mispredict;
      logic [HIST_BITS-1:0] history;     // Snapshot returned from fetch
   } update_t;

   // Word aligned PC bits [6:2]
   function automatic logic [INDEX_BITS-1:0] pc_index(input logic [ADDR_BITS-1:0] pc);
      return pc[INDEX_BITS+1:2];
   endfunction

   // Saturating step, up means toward taken / toward gshare
   function automatic logic [1:0] cnt_train(input logic [1:0] cnt, input logic up);
      logic [1:0] nxt;
      nxt = cnt;
      if (up && (cnt != CNT_STRONG_T)) begin
         nxt = cnt + 2'd1;
      end else if (!up && (cnt != CNT_STRONG_NT)) begin
         nxt = cnt - 2'd1;
      end
      return nxt;
   endfunction

endpackage

`default_nettype wire

/* rtl/bimodal_table.sv */
`timescale 1ns/1ps
`default_nettype none

module bimodal_table (
      input  wire logic                                     clk,
      input  wire logic                                     reset,
      input  wire bp_pkg::fetch_lane_t [bp_pkg::LANES-1:0]  fetch_i,
      input  wire bp_pkg::update_t                          update_i,
      output logic [bp_pkg::LANES-1:0]                      lane_taken_o,
      output logic                                          upd_pred_o
   );

   //////////////////////////////
   // Counter storage
   //////////////////////////////
   logic [1:0] cnt_q [bp_pkg::ENTRIES];

   logic [bp_pkg::INDEX_BITS-1:0] lane_idx [bp_pkg::LANES];
   logic [bp_pkg::INDEX_BITS-1:0] upd_idx;

   // Plain PC index per lane
   always_comb begin
      for (int l = 0; l < bp_pkg::LANES; l++) begin
         lane_idx[l] = bp_pkg::pc_index(fetch_i[l].pc);
      end
   end

   assign upd_idx = bp_pkg::pc_index(update_i.pc);

   //////////////////////////////
   // Lookup
   //////////////////////////////
   always_comb begin
      for (int l = 0; l < bp_pkg::LANES; l++) begin
         lane_taken_o[l] = cnt_q[lane_idx[l]][1];   // MSB is the direction
      end
   end

   // Old counter at the update slot, lets the chooser judge this table
   assign upd_pred_o = cnt_q[upd_idx][1];

   //////////////////////////////
   // Training
   //////////////////////////////
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < bp_pkg::ENTRIES; i++) begin
            cnt_q[i] <= bp_pkg::CNT_RESET;
         end
      end else if (update_i.valid) begin
         cnt_q[upd_idx] <= bp_pkg::cnt_train(cnt_q[upd_idx], update_i.taken);
      end
   end

   // Execute only flags a mispredict on a real resolution
   mispredict_needs_valid: assert property (
      @(posedge clk) disable iff (!reset)
      update_i.mispredict |-> update_i.valid
   ) else $error("bimodal_table: mispredict without update valid");

endmodule

`default_nettype wire

/* rtl/gshare_table.sv */
`timescale 1ns/1ps
`default_nettype none

module gshare_table (
      input  wire logic                                     clk,
      input  wire logic                                     reset,
      input  wire logic                                     base_valid_i,
      input  wire bp_pkg::fetch_lane_t [bp_pkg::LANES-1:0]  fetch_i,
      input  wire logic                                     lane0_final_i,
      input  wire logic                                     lane1_final_i,
      input  wire bp_pkg::update_t                          update_i,
      output logic [bp_pkg::LANES-1:0]                      lane_taken_o,
      output logic [bp_pkg::LANES-1:0][bp_pkg::HIST_BITS-1:0] lane_hist_o,
      output logic                                          upd_pred_o
   );

   // Shift one outcome into a history word
   function automatic logic [bp_pkg::HIST_BITS-1:0] hist_push(
         input logic [bp_pkg::HIST_BITS-1:0] hist,
         input logic                         taken
      );
      return {hist[bp_pkg::HIST_BITS-2:0], taken};
   endfunction

   //////////////////////////////
   // State
   //////////////////////////////
   logic [1:0]                    cnt_q [bp_pkg::ENTRIES];
   logic [bp_pkg::HIST_BITS-1:0]  hist_q;      // Speculative global history
   logic [bp_pkg::HIST_BITS-1:0]  hist_d;

   logic                          live0;
   logic                          live1;
   logic [bp_pkg::HIST_BITS-1:0]  hist0;
   logic [bp_pkg::HIST_BITS-1:0]  hist1;
   logic [bp_pkg::HIST_BITS-1:0]  hist_spec;   // After the whole group
   logic [bp_pkg::HIST_BITS-1:0]  hist_fix;    // Restore value on mispredict
   logic                          restore;

   logic [bp_pkg::INDEX_BITS-1:0] idx0;
   logic [bp_pkg::INDEX_BITS-1:0] idx1;
   logic [bp_pkg::INDEX_BITS-1:0] upd_idx;

   //////////////////////////////
   // Per-lane history
   //////////////////////////////
   assign live0 = fetch_i[0].is_branch;
   assign live1 = fetch_i[1].is_branch & ~fetch_i[1].ignore;

   assign hist0 = hist_q;
   // Lane 1 sees lane 0's final call if lane 0 is a branch
   assign hist1 = live0 ? hist_push(hist_q, lane0_final_i) : hist_q;
   assign hist_spec = live1 ? hist_push(hist1, lane1_final_i) : hist1;

   assign lane_hist_o[0] = hist0;
   assign lane_hist_o[1] = hist1;

   //////////////////////////////
   // Lookup
   //////////////////////////////
   assign idx0 = bp_pkg::pc_index(fetch_i[0].pc) ^ hist0;
   assign idx1 = bp_pkg::pc_index(fetch_i[1].pc) ^ hist1;

   assign lane_taken_o[0] = cnt_q[idx0][1];
   assign lane_taken_o[1] = cnt_q[idx1][1];

   // Train at the index fetch actually used
   assign upd_idx    = bp_pkg::pc_index(update_i.pc) ^ update_i.history;
   assign upd_pred_o = cnt_q[upd_idx][1];

   //////////////////////////////
   // History update
   //////////////////////////////
   assign restore  = update_i.valid & update_i.mispredict;
   assign hist_fix = hist_push(update_i.history, update_i.taken);

   always_comb begin
      hist_d = hist_q;
      if (restore) begin
         hist_d = hist_fix;   // Wins over a new fetch group
      end else if (base_valid_i) begin
         hist_d = hist_spec;
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         hist_q <= '0;
      end else begin
         hist_q <= hist_d;
      end
   end

   // Counter training
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < bp_pkg::ENTRIES; i++) begin
            cnt_q[i] <= bp_pkg::CNT_RESET;
         end
      end else if (update_i.valid) begin
         cnt_q[upd_idx] <= bp_pkg::cnt_train(cnt_q[upd_idx], update_i.taken);
      end
   end

   // Lane finals and update snapshot must never leak X into the history
   hist_known: assert property (
      @(posedge clk) disable iff (!reset)
      !$isunknown(hist_q)
   ) else $error("gshare_table: global history unknown");

endmodule

`default_nettype wire

/* rtl/choice_table.sv */
`timescale 1ns/1ps
`default_nettype none

module choice_table (
      input  wire logic                                     clk,
      input  wire logic                                     reset,
      input  wire bp_pkg::fetch_lane_t [bp_pkg::LANES-1:0]  fetch_i,
      input  wire bp_pkg::update_t                          update_i,
      input  wire logic [bp_pkg::LANES-1:0]                 bim_taken_i,
      input  wire logic [bp_pkg::LANES-1:0]                 gsh_taken_i,
      input  wire logic                                     bim_upd_i,
      input  wire logic                                     gsh_upd_i,
      output logic [bp_pkg::LANES-1:0]                      pred_o,
      output logic                                          lane0_final_o
   );

   //////////////////////////////
   // Chooser counters
   //////////////////////////////
   // High half prefers gshare, low half prefers bimodal
   logic [1:0] cnt_q [bp_pkg::ENTRIES];

   logic [bp_pkg::INDEX_BITS-1:0] lane_idx [bp_pkg::LANES];
   logic [bp_pkg::LANES-1:0]      use_gsh;
   logic [bp_pkg::INDEX_BITS-1:0] upd_idx;
   logic                          disagree;
   logic                          gsh_right;

   always_comb begin
      for (int l = 0; l < bp_pkg::LANES; l++) begin
         lane_idx[l] = bp_pkg::pc_index(fetch_i[l].pc);
         use_gsh[l]  = cnt_q[lane_idx[l]][1];
      end
   end

   //////////////////////////////
   // Final selection
   //////////////////////////////
   always_comb begin
      for (int l = 0; l < bp_pkg::LANES; l++) begin
         pred_o[l] = use_gsh[l] ? gsh_taken_i[l] : bim_taken_i[l];
      end
   end

   // Feeds gshare's lane 1 history, no loop since lane 0 stands alone
   assign lane0_final_o = pred_o[0];

   //////////////////////////////
   // Training
   //////////////////////////////
   assign upd_idx   = bp_pkg::pc_index(update_i.pc);
   assign disagree  = bim_upd_i ^ gsh_upd_i;          // Only then is one side right
   assign gsh_right = (gsh_upd_i == update_i.taken);

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < bp_pkg::ENTRIES; i++) begin
            cnt_q[i] <= bp_pkg::CNT_RESET;
         end
      end else if (update_i.valid && disagree) begin
         // Up toward gshare, down toward bimodal
         cnt_q[upd_idx] <= bp_pkg::cnt_train(cnt_q[upd_idx], gsh_right);
      end
   end

   // An unknown select would hand fetch neither component's answer
   for (genvar l = 0; l < bp_pkg::LANES; l++) begin : g_known_chk
      pred_known: assert property (
         @(posedge clk) disable iff (!reset)
         !$isunknown({use_gsh[l], pred_o[l]})
      ) else $error("choice_table: lane %0d prediction unknown", l);
   end

endmodule

`default_nettype wire

/* rtl/tournament_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module tournament_predictor (
      input  wire logic                                     clk,
      input  wire logic                                     reset,
      input  wire logic                                     base_valid_i,
      input  wire bp_pkg::fetch_lane_t [bp_pkg::LANES-1:0]  fetch_i,
      input  wire bp_pkg::update_t                          update_i,
      output bp_pkg::pred_lane_t [bp_pkg::LANES-1:0]        pred_o
   );

   //////////////////////////////
   // Internal nets
   //////////////////////////////
   logic [bp_pkg::LANES-1:0]                    bim_taken;
   logic [bp_pkg::LANES-1:0]                    gsh_taken;
   logic [bp_pkg::LANES-1:0]                    final_taken;
   logic [bp_pkg::LANES-1:0][bp_pkg::HIST_BITS-1:0] lane_hist;
   logic                                        bim_upd;
   logic                                        gsh_upd;
   logic                                        lane0_final;   // Back into gshare

   bimodal_table u_bimodal (
      .clk          (clk),
      .reset        (reset),
      .fetch_i      (fetch_i),
      .update_i     (update_i),
      .lane_taken_o (bim_taken),
      .upd_pred_o   (bim_upd)
   );

   gshare_table u_gshare (
      .clk           (clk),
      .reset         (reset),
      .base_valid_i  (base_valid_i),
      .fetch_i       (fetch_i),
      .lane0_final_i (lane0_final),
      .lane1_final_i (final_taken[1]),   // Only reaches the history register
      .update_i      (update_i),
      .lane_taken_o  (gsh_taken),
      .lane_hist_o   (lane_hist),
      .upd_pred_o    (gsh_upd)
   );

   choice_table u_choice (
      .clk           (clk),
      .reset         (reset),
      .fetch_i       (fetch_i),
      .update_i      (update_i),
      .bim_taken_i   (bim_taken),
      .gsh_taken_i   (gsh_taken),
      .bim_upd_i     (bim_upd),
      .gsh_upd_i     (gsh_upd),
      .pred_o        (final_taken),
      .lane0_final_o (lane0_final)
   );

   // Taken from the chooser, history from gshare
   for (genvar l = 0; l < bp_pkg::LANES; l++) begin : g_pred
      assign pred_o[l].taken   = final_taken[l];
      assign pred_o[l].history = lane_hist[l];
   end

endmodule

`default_nettype wire

/* test/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////
// Reference state
//////////////////////////////
logic [1:0]                   bim_cnt [bp_pkg::ENTRIES];
logic [1:0]                   gsh_cnt [bp_pkg::ENTRIES];
logic [1:0]                   cho_cnt [bp_pkg::ENTRIES];   // MSB set prefers gshare
logic [bp_pkg::HIST_BITS-1:0] glob_hist;
logic [15:0]                  lfsr_q;

function automatic logic [1:0] sat_step(input logic [1:0] cnt, input logic up);
   if (up) begin
      return (cnt == 2'b11) ? cnt : cnt + 2'd1;
   end
   return (cnt == 2'b00) ? cnt : cnt - 2'd1;
endfunction

function automatic logic [bp_pkg::HIST_BITS-1:0] hist_shift(
      input logic [bp_pkg::HIST_BITS-1:0] h, input logic t);
   return {h[bp_pkg::HIST_BITS-2:0], t};
endfunction

// Final call for one lane, PC bits 6 to 2 pick the slot
function automatic logic lookup(input logic [31:0] pc, input logic [bp_pkg::HIST_BITS-1:0] h);
   if (cho_cnt[pc[6:2]][1]) begin
      return gsh_cnt[pc[6:2] ^ h][1];
   end
   return bim_cnt[pc[6:2]][1];
endfunction

function automatic void model_reset();
   for (int i = 0; i < bp_pkg::ENTRIES; i++) begin
      bim_cnt[i] = bp_pkg::CNT_RESET;
      gsh_cnt[i] = bp_pkg::CNT_RESET;
      cho_cnt[i] = bp_pkg::CNT_RESET;
   end
   glob_hist = '0;
endfunction

// Lane 1 history picks up lane 0's final call when lane 0 is a branch
function automatic pred_group_t predict_group(input fetch_group_t f);
   pred_group_t p;
   p[0].history = glob_hist;
   p[0].taken   = lookup(f[0].pc, glob_hist);
   p[1].history = f[0].is_branch ? hist_shift(glob_hist, p[0].taken) : glob_hist;
   p[1].taken   = lookup(f[1].pc, p[1].history);
   return p;
endfunction

// One clock edge, all training uses the old counters
function automatic void model_step(input fetch_group_t f, input logic bv,
      input bp_pkg::update_t u, input pred_group_t p);
   logic [4:0] slot;
   logic [4:0] gslot;
   logic       gsh_old;
   slot    = u.pc[6:2];
   gslot   = slot ^ u.history;
   gsh_old = gsh_cnt[gslot][1];
   if (u.valid) begin
      if (bim_cnt[slot][1] != gsh_old) begin   // Chooser moves on disagreement only
         cho_cnt[slot] = sat_step(cho_cnt[slot], gsh_old == u.taken);
      end
      bim_cnt[slot]  = sat_step(bim_cnt[slot], u.taken);
      gsh_cnt[gslot] = sat_step(gsh_cnt[gslot], u.taken);
   end
   if (u.valid && u.mispredict) begin
      glob_hist = hist_shift(u.history, u.taken);
   end else if (bv) begin
      if (f[0].is_branch) begin
         glob_hist = hist_shift(glob_hist, p[0].taken);
      end
      if (f[1].is_branch && !f[1].ignore) begin
         glob_hist = hist_shift(glob_hist, p[1].taken);
      end
   end
endfunction

// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] r;
   logic        fb;
   r = '0;
   for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[30:0], fb};
   end
   return r;
endfunction

`endif

/* test/tb_tournament.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tournament;

   localparam int CLK_PERIOD      = 100;
   localparam int RESET_CYCLES    = 10;
   localparam int DIRECTED_CYCLES = 90;    // Three resets plus the directed steps
   localparam int RANDOM_CYCLES   = 400;
   localparam int WATCHDOG_CYCLES = DIRECTED_CYCLES + RANDOM_CYCLES + 50;
   localparam logic [15:0] LFSR_SEED = 16'd5;
   localparam logic [31:0] PC_A = 32'h0000_0040;   // Slot 16
   localparam logic [31:0] PC_P = 32'h0000_0028;   // Slot 10

   typedef bp_pkg::fetch_lane_t [bp_pkg::LANES-1:0] fetch_group_t;
   typedef bp_pkg::pred_lane_t [bp_pkg::LANES-1:0]  pred_group_t;

   localparam bp_pkg::update_t NO_UPDATE = '0;

   logic            clk;
   logic            reset;
   logic            base_valid;
   fetch_group_t    fetch;
   bp_pkg::update_t upd;
   pred_group_t     pred;

   int    err_total = 0;
   int    check_cnt = 0;
   int    test_cnt  = 0;
   int    test_err_base;
   string test_name;

   `include "tb_model.svh"

   tournament_predictor UUT (
      .clk          (clk),
      .reset        (reset),
      .base_valid_i (base_valid),
      .fetch_i      (fetch),
      .update_i     (upd),
      .pred_o       (pred)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   task automatic drive_cycle(input logic bv, input fetch_group_t f, input bp_pkg::update_t u);
      @(posedge clk);
      base_valid <= bv;
      fetch      <= f;
      upd        <= u;
   endtask

   task automatic resolve(input logic bv, input fetch_group_t f, input logic [31:0] pc,
         input logic t, input logic misp, input logic [4:0] h);
      drive_cycle(bv, f, '{valid: 1'b1, pc: pc, taken: t, mispredict: misp, history: h});
   endtask

   task automatic look(input fetch_group_t f);
      drive_cycle(1'b0, f, NO_UPDATE);
      @(negedge clk);
   endtask

   task automatic apply_reset();
      @(posedge clk);
      reset      <= 1'b0;
      base_valid <= 1'b0;
      upd        <= NO_UPDATE;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b1;
   endtask

   function automatic fetch_group_t mk_fetch(input logic [31:0] pc0, input logic br0,
         input logic [31:0] pc1, input logic br1, input logic ign1);
      fetch_group_t f;
      f[0] = '{pc: pc0, is_branch: br0, ignore: 1'b0};
      f[1] = '{pc: pc1, is_branch: br1, ignore: ign1};
      return f;
   endfunction

   task automatic expect_lane(input int l, input logic t, input logic [4:0] h, input string what);
      check_cnt++;
      assert (pred[l].taken === t && pred[l].history === h) else begin
         $display("FAILED at %0d ns: %s, lane %0d gave %0b/%b, expected %0b/%b",
                  $time, what, l, pred[l].taken, pred[l].history, t, h);
         err_total++;
      end
   endtask

   task automatic start_test(input string name);
      test_name     = name;
      test_err_base = err_total;
      test_cnt++;
   endtask

   task automatic finish_test();
      if (err_total == test_err_base) begin
         $display("Test %0d %s: ok", test_cnt, test_name);
      end else begin
         $display("Test %0d %s: %0d errors", test_cnt, test_name, err_total - test_err_base);
      end
   endtask

   task automatic random_traffic();
      fetch_group_t    f;
      bp_pkg::update_t u;
      logic            bv;
      for (int c = 0; c < RANDOM_CYCLES; c++) begin
         for (int l = 0; l < bp_pkg::LANES; l++) begin
            f[l].pc        = {23'd0, 7'(rand_bits(7)), 2'b00};
            f[l].is_branch = 1'(rand_bits(1));
            f[l].ignore    = 1'(rand_bits(1));
         end
         bv           = 1'(rand_bits(1));
         u.valid      = 1'(rand_bits(1));
         u.pc         = {23'd0, 7'(rand_bits(7)), 2'b00};
         u.taken      = 1'(rand_bits(1));
         u.mispredict = u.valid & 1'(rand_bits(1));
         u.history    = 5'(rand_bits(5));
         drive_cycle(bv, f, u);
      end
      look(f);
   endtask

   //////////////////////////////
   // Model compare, every cycle
   //////////////////////////////
   always @(negedge clk) begin : compare
      pred_group_t exp_pred;
      if (!reset) begin
         model_reset();
      end else begin
         exp_pred = predict_group(fetch);
         for (int l = 0; l < bp_pkg::LANES; l++) begin
            check_cnt++;
            assert (pred[l] === exp_pred[l]) else begin
               $display("FAILED at %0d ns: lane %0d gave %0b/%b, model %0b/%b", $time, l,
                        pred[l].taken, pred[l].history, exp_pred[l].taken, exp_pred[l].history);
               err_total++;
            end
         end
         model_step(fetch, base_valid, upd, exp_pred);
      end
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
      $display("Checks failed");
      $finish;
   end

   initial begin : stimulus
      fetch_group_t g;
      fetch_group_t gi;
      fetch_group_t fa;
      fetch_group_t fp;
      lfsr_q      = LFSR_SEED;
      reset      <= 1'b0;
      base_valid <= 1'b0;
      fetch      <= '0;
      upd        <= NO_UPDATE;
      g  = mk_fetch(32'h100, 1'b1, 32'h204, 1'b1, 1'b0);
      gi = mk_fetch(32'h100, 1'b1, 32'h204, 1'b1, 1'b1);
      fa = mk_fetch(PC_A, 1'b0, PC_A, 1'b0, 1'b0);
      fp = mk_fetch(PC_P, 1'b1, PC_A, 1'b0, 1'b0);

      start_test("reset state");
      apply_reset();
      look(g);
      expect_lane(0, 1'b1, 5'b00000, "weakly taken after reset");
      expect_lane(1, 1'b1, 5'b00001, "lane 1 sees lane 0 shifted in");
      finish_test();

      start_test("counter saturation");
      resolve(1'b0, fa, PC_A, 1'b0, 1'b0, 5'd0);
      resolve(1'b0, fa, PC_A, 1'b0, 1'b0, 5'd0);
      look(fa);
      expect_lane(0, 1'b0, 5'd0, "not taken after two updates");
      resolve(1'b0, fa, PC_A, 1'b0, 1'b0, 5'd0);
      resolve(1'b0, fa, PC_A, 1'b1, 1'b0, 5'd0);
      look(fa);
      expect_lane(0, 1'b0, 5'd0, "saturated counter after one taken");
      resolve(1'b0, fa, PC_A, 1'b1, 1'b0, 5'd0);
      look(fa);
      expect_lane(0, 1'b1, 5'd0, "taken again after two taken");
      finish_test();

      start_test("speculative history");
      apply_reset();
      drive_cycle(1'b1, g, NO_UPDATE);
      @(negedge clk);
      expect_lane(1, 1'b1, 5'b00001, "lane 1 with lane 0 shifted in");
      drive_cycle(1'b1, gi, NO_UPDATE);
      @(negedge clk);
      expect_lane(0, 1'b1, 5'b00011, "both live lanes shifted");
      look(g);
      expect_lane(0, 1'b1, 5'b00111, "ignored lane 1 left out");
      finish_test();

      start_test("mispredict restore");
      resolve(1'b1, g, 32'h314, 1'b0, 1'b1, 5'b10100);
      @(negedge clk);
      expect_lane(0, 1'b1, 5'b00111, "history holds until the edge");
      look(g);
      expect_lane(0, 1'b1, 5'b01000, "snapshot plus outcome");
      expect_lane(1, 1'b1, 5'b10001, "lane 1 after restore");
      finish_test();

      start_test("chooser training");
      apply_reset();
      resolve(1'b0, fp, PC_P, 1'b0, 1'b0, 5'b00001);
      look(fp);
      expect_lane(0, 1'b1, 5'd0, "still follows gshare");
      resolve(1'b0, fp, PC_P, 1'b0, 1'b0, 5'b00010);
      look(fp);
      expect_lane(0, 1'b0, 5'd0, "follows bimodal");
      resolve(1'b0, fp, PC_P, 1'b0, 1'b0, 5'b00100);
      look(fp);
      expect_lane(0, 1'b0, 5'd0, "bimodal preferred");
      finish_test();

      start_test("random traffic");
      random_traffic();
      finish_test();

      $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_total);
      if (err_total == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
+incdir+test
rtl/bp_pkg.sv
rtl/bimodal_table.sv
rtl/gshare_table.sv
rtl/choice_table.sv
rtl/tournament_predictor.sv
test/tb_tournament.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the tournament predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_tournament -o tb_tournament
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/tb_tournament)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
   exit 0
fi
exit 1
